/* rtl/hp_tx_pkg.sv */
//////////////////////////////
// shared widths, TLP fields and FSM encodings of the huge-page transmit engine
//////////////////////////////

package hp_tx_pkg;

    localparam int QWORD_W    = 64;                     // one beat on the trn bus
    localparam int BUF_AW     = 9;                      // read buffer depth 512
    localparam int QCNT_W     = 5;                      // 1..31 qwords per TLP
    localparam int LEN_W      = 10;                     // TLP length field, DWs
    localparam int REQ_ID_W   = 16;
    localparam int TAG_BITS   = 4;                      // low TLP number bits in tag
    localparam int PAGE_CNT_W = 32;

    localparam logic [6:0]         FMT_TYPE_MWR64 = 7'b1100000;  // 4DW header, with data
    localparam logic [QWORD_W-1:0] PAGE_HDR_BYTES = 128;         // page count lives here
    localparam logic [LEN_W-1:0]   CLOSE_LEN_DW   = 2;

    //////////////////////////////
    // FSM states and beat kinds
    //////////////////////////////
    typedef enum logic [3:0] {
        IDLE,                                           // wait for a filled slot
        READY,                                          // accept producer strobes
        DATA_HDR,
        DATA_ADDR,
        DATA_BODY,
        CLOSE_HDR,
        CLOSE_ADDR,
        CLOSE_CNT,
        IRQ                                             // hold interrupt request
    } tx_state_t;

    typedef enum logic [2:0] {
        BEAT_NONE,
        BEAT_DATA_HDR,
        BEAT_DATA_ADDR,
        BEAT_PAYLOAD,
        BEAT_CLOSE_HDR,
        BEAT_CLOSE_ADDR,
        BEAT_CLOSE_CNT
    } beat_sel_t;

endpackage

/* rtl/hp_page_slots.sv */
//////////////////////////////
// two-slot huge page hand-off with a free pulse back to the host
//////////////////////////////

module hp_page_slots (
    input  logic                            trn_clk,
    input  logic                            reset_n,
    input  logic [hp_tx_pkg::QWORD_W-1:0]   huge_page_addr_1,
    input  logic [hp_tx_pkg::QWORD_W-1:0]   huge_page_addr_2,
    input  logic                            huge_page_status_1,
    input  logic                            huge_page_status_2,
    input  logic                            page_return,        // close TLP on its way
    output logic [hp_tx_pkg::QWORD_W-1:0]   page_base,
    output logic                            page_available,
    output logic                            huge_page_free_1,
    output logic                            huge_page_free_2
);

    logic slot_sel;                                     // 0 slot 1, 1 slot 2
    logic slot_filled;

    assign slot_filled = slot_sel ? huge_page_status_2 : huge_page_status_1;

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            slot_sel         <= 1'b0;
            page_available   <= 1'b0;
            huge_page_free_1 <= 1'b0;
            huge_page_free_2 <= 1'b0;
        end else begin
            huge_page_free_1 <= 1'b0;                   // pulses only
            huge_page_free_2 <= 1'b0;
            if (!page_available) begin
                page_available <= slot_filled;          // host handed this slot over
            end else if (page_return) begin
                page_available   <= 1'b0;
                huge_page_free_1 <= !slot_sel;
                huge_page_free_2 <= slot_sel;
                slot_sel         <= !slot_sel;          // alternate slots
            end
        end
    end

    // address held for the whole page and read by the close beat after return
    always_ff @(posedge trn_clk) begin
        if (!page_available && slot_filled) begin
            page_base <= slot_sel ? huge_page_addr_2 : huge_page_addr_1;
        end
    end

    a_return_held : assert property (@(posedge trn_clk) disable iff (!reset_n)
        page_return |-> page_available)
        else $error("page returned while no page is held");

endmodule

/* rtl/hp_tx_fsm.sv */
//////////////////////////////
// sequences data TLPs, page close TLP and interrupt handshake
//////////////////////////////

module hp_tx_fsm (
    input  logic                    trn_clk,
    input  logic                    reset_n,
    input  logic                    trigger_tlp,
    input  logic                    send_last_tlp_change_huge_page,
    input  logic                    change_huge_page,
    input  logic                    page_available,
    input  logic                    last_beat,
    input  logic                    cfg_interrupt_rdy_n,
    output logic                    load_page,
    output logic                    start_tlp,
    output logic                    next_beat,
    output logic                    end_tlp,
    output hp_tx_pkg::beat_sel_t    beat_sel,
    output logic                    page_return,
    output logic                    trigger_tlp_ack,
    output logic                    change_huge_page_ack,
    output logic                    tx_ready,
    output logic                    cfg_interrupt_n
);

    hp_tx_pkg::tx_state_t state;
    hp_tx_pkg::tx_state_t state_nxt;
    logic                 remember;                     // close owed after send_last
    logic                 remember_nxt;

    always_comb begin
        state_nxt    = state;
        remember_nxt = remember;
        case (state)
            hp_tx_pkg::IDLE:       if (page_available) state_nxt = hp_tx_pkg::READY;
            hp_tx_pkg::READY: begin
                if (remember || change_huge_page) begin     // change wins
                    state_nxt    = hp_tx_pkg::CLOSE_HDR;
                    remember_nxt = 1'b0;
                end else if (send_last_tlp_change_huge_page) begin
                    state_nxt    = hp_tx_pkg::DATA_HDR;
                    remember_nxt = 1'b1;
                end else if (trigger_tlp) begin
                    state_nxt = hp_tx_pkg::DATA_HDR;
                end
            end
            hp_tx_pkg::DATA_HDR:   state_nxt = hp_tx_pkg::DATA_ADDR;
            hp_tx_pkg::DATA_ADDR:  state_nxt = hp_tx_pkg::DATA_BODY;
            hp_tx_pkg::DATA_BODY:  if (last_beat) state_nxt = hp_tx_pkg::READY;
            hp_tx_pkg::CLOSE_HDR:  state_nxt = hp_tx_pkg::CLOSE_ADDR;
            hp_tx_pkg::CLOSE_ADDR: state_nxt = hp_tx_pkg::CLOSE_CNT;
            hp_tx_pkg::CLOSE_CNT:  state_nxt = hp_tx_pkg::IRQ;
            hp_tx_pkg::IRQ:        if (!cfg_interrupt_rdy_n) state_nxt = hp_tx_pkg::IDLE;
            default:               state_nxt = hp_tx_pkg::IDLE;
        endcase
    end

    // formatter registers the beat so trn beats line up with state
    always_comb begin
        case (state_nxt)
            hp_tx_pkg::DATA_HDR:   beat_sel = hp_tx_pkg::BEAT_DATA_HDR;
            hp_tx_pkg::DATA_ADDR:  beat_sel = hp_tx_pkg::BEAT_DATA_ADDR;
            hp_tx_pkg::DATA_BODY:  beat_sel = hp_tx_pkg::BEAT_PAYLOAD;
            hp_tx_pkg::CLOSE_HDR:  beat_sel = hp_tx_pkg::BEAT_CLOSE_HDR;
            hp_tx_pkg::CLOSE_ADDR: beat_sel = hp_tx_pkg::BEAT_CLOSE_ADDR;
            hp_tx_pkg::CLOSE_CNT:  beat_sel = hp_tx_pkg::BEAT_CLOSE_CNT;
            default:               beat_sel = hp_tx_pkg::BEAT_NONE;
        endcase
    end

    assign load_page   = (state == hp_tx_pkg::IDLE);            // page origin and count clear
    assign start_tlp   = (state == hp_tx_pkg::READY) && (state_nxt == hp_tx_pkg::DATA_HDR);
    assign next_beat   = (state == hp_tx_pkg::DATA_HDR) || (state == hp_tx_pkg::DATA_ADDR) ||
                         (state == hp_tx_pkg::DATA_BODY);       // buffer read runs ahead
    assign end_tlp     = (state == hp_tx_pkg::DATA_BODY) && last_beat;
    assign page_return = (state == hp_tx_pkg::CLOSE_HDR);       // free lands on addr beat

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state                <= hp_tx_pkg::IDLE;
            remember             <= 1'b0;
            trigger_tlp_ack      <= 1'b0;
            change_huge_page_ack <= 1'b0;
            tx_ready             <= 1'b0;
            cfg_interrupt_n      <= 1'b1;
        end else begin
            state                <= state_nxt;
            remember             <= remember_nxt;
            trigger_tlp_ack      <= (state_nxt == hp_tx_pkg::DATA_ADDR);
            change_huge_page_ack <= (state_nxt == hp_tx_pkg::CLOSE_ADDR);
            tx_ready             <= (state_nxt == hp_tx_pkg::READY) && !remember_nxt;
            cfg_interrupt_n      <= (state_nxt != hp_tx_pkg::IRQ);   // held until taken
        end
    end

    a_irq_rdy_pending : assert property (@(posedge trn_clk) disable iff (!reset_n)
        !cfg_interrupt_rdy_n |-> !cfg_interrupt_n)
        else $error("interrupt taken with no request pending");

endmodule

/* rtl/hp_tx_counters.sv */
//////////////////////////////
// read pointers, host address, page count and TLP number bookkeeping
//////////////////////////////

module hp_tx_counters (
    input  logic                                trn_clk,
    input  logic                                reset_n,
    input  logic                                load_page,
    input  logic                                start_tlp,
    input  logic                                next_beat,
    input  logic                                end_tlp,
    input  logic [hp_tx_pkg::QWORD_W-1:0]       page_base,
    input  logic [hp_tx_pkg::QCNT_W-1:0]        qwords_to_send,
    output logic [hp_tx_pkg::BUF_AW-1:0]        rd_addr,
    output logic [hp_tx_pkg::BUF_AW-1:0]        commited_rd_address,
    output logic [hp_tx_pkg::QWORD_W-1:0]       host_addr,
    output logic [hp_tx_pkg::TAG_BITS-1:0]      tlp_tag,         // low bits of TLP number
    output logic [hp_tx_pkg::QCNT_W-1:0]        qwords_in_tlp,
    output logic [hp_tx_pkg::PAGE_CNT_W-1:0]    page_qwords,
    output logic                                last_beat
);

    logic [hp_tx_pkg::QCNT_W-1:0] n_q;                  // qwords of TLP in flight
    logic [hp_tx_pkg::QCNT_W:0]   beat_cnt;             // hdr, addr, then payload

    assign qwords_in_tlp = start_tlp ? qwords_to_send : n_q;   // header built same cycle
    assign last_beat     = (beat_cnt == {1'b0, n_q} + 1'b1);

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr             <= '0;
            commited_rd_address <= '0;
            n_q                 <= '0;
            beat_cnt            <= '0;
            host_addr           <= '0;
            page_qwords         <= '0;
            tlp_tag             <= '0;
        end else begin
            if (start_tlp) begin
                rd_addr             <= commited_rd_address;     // first entry of this TLP
                commited_rd_address <= commited_rd_address +
                    {{(hp_tx_pkg::BUF_AW-hp_tx_pkg::QCNT_W){1'b0}}, qwords_to_send};
                n_q                 <= qwords_to_send;
                beat_cnt            <= '0;
            end else if (next_beat) begin
                rd_addr  <= rd_addr + 1'b1;
                beat_cnt <= beat_cnt + 1'b1;
            end

            if (load_page) begin
                host_addr   <= page_base + hp_tx_pkg::PAGE_HDR_BYTES;   // skip count area
                page_qwords <= '0;
            end else if (end_tlp) begin
                host_addr   <= host_addr +
                    {{(hp_tx_pkg::QWORD_W-hp_tx_pkg::QCNT_W-3){1'b0}}, n_q, 3'b000};
                page_qwords <= page_qwords +
                    {{(hp_tx_pkg::PAGE_CNT_W-hp_tx_pkg::QCNT_W){1'b0}}, n_q};
                tlp_tag     <= tlp_tag + 1'b1;                  // runs on across pages
            end
        end
    end

    a_n_nonzero : assert property (@(posedge trn_clk) disable iff (!reset_n)
        start_tlp |-> (qwords_to_send != '0))
        else $error("TLP started with zero qwords");

endmodule

/* rtl/hp_tlp_formatter.sv */
//////////////////////////////
// builds and registers each trn beat of data and close TLPs
//////////////////////////////

module hp_tlp_formatter (
    input  logic                                trn_clk,
    input  logic                                reset_n,
    input  hp_tx_pkg::beat_sel_t                beat_sel,
    input  logic [hp_tx_pkg::REQ_ID_W-1:0]      cfg_completer_id,
    input  logic [hp_tx_pkg::QCNT_W-1:0]        qwords_in_tlp,
    input  logic [hp_tx_pkg::TAG_BITS-1:0]      tlp_tag,
    input  logic [hp_tx_pkg::QWORD_W-1:0]       host_addr,
    input  logic [hp_tx_pkg::QWORD_W-1:0]       page_base,
    input  logic [hp_tx_pkg::PAGE_CNT_W-1:0]    page_qwords,
    input  logic [hp_tx_pkg::QWORD_W-1:0]       rd_data,
    output logic [hp_tx_pkg::QWORD_W-1:0]       trn_td,
    output logic [hp_tx_pkg::QWORD_W/8-1:0]     trn_trem_n,
    output logic                                trn_tsof_n,
    output logic                                trn_teof_n,
    output logic                                trn_tsrc_rdy_n
);

    localparam int PAD_W = 32 - 8 - hp_tx_pkg::LEN_W;  // reserved, TC, TD, EP, attr

    logic [hp_tx_pkg::LEN_W-1:0]      data_len;         // qwords times two
    logic [hp_tx_pkg::QCNT_W-1:0]     pay_cnt;          // payload beats sent
    logic [hp_tx_pkg::QCNT_W-1:0]     pay_cnt_nxt;
    logic [hp_tx_pkg::QWORD_W-1:0]    data_swapped;
    logic [hp_tx_pkg::PAGE_CNT_W-1:0] cnt_swapped;

    assign data_len     = {{(hp_tx_pkg::LEN_W-hp_tx_pkg::QCNT_W-1){1'b0}}, qwords_in_tlp, 1'b0};
    assign pay_cnt_nxt  = pay_cnt + 1'b1;
    assign data_swapped = {<<8{rd_data}};               // host sees buffer byte order
    assign cnt_swapped  = {<<8{page_qwords}};

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            trn_td         <= '0;
            trn_trem_n     <= '1;
            trn_tsof_n     <= 1'b1;
            trn_teof_n     <= 1'b1;
            trn_tsrc_rdy_n <= 1'b1;
            pay_cnt        <= '0;
        end else begin
            trn_tsof_n     <= 1'b1;
            trn_teof_n     <= 1'b1;
            trn_tsrc_rdy_n <= (beat_sel == hp_tx_pkg::BEAT_NONE);
            trn_trem_n     <= (beat_sel == hp_tx_pkg::BEAT_NONE) ? '1 : '0;  // full qwords
            case (beat_sel)
                hp_tx_pkg::BEAT_DATA_HDR: begin
                    trn_td     <= {1'b0, hp_tx_pkg::FMT_TYPE_MWR64, {PAD_W{1'b0}}, data_len,
                                   cfg_completer_id,
                                   {(8-hp_tx_pkg::TAG_BITS){1'b0}}, tlp_tag,
                                   8'hFF};                      // all byte enables
                    trn_tsof_n <= 1'b0;
                    pay_cnt    <= '0;
                end
                hp_tx_pkg::BEAT_DATA_ADDR:  trn_td <= host_addr;
                hp_tx_pkg::BEAT_PAYLOAD: begin
                    trn_td     <= data_swapped;
                    trn_teof_n <= (pay_cnt_nxt != qwords_in_tlp);   // last payload qword
                    pay_cnt    <= pay_cnt_nxt;
                end
                hp_tx_pkg::BEAT_CLOSE_HDR: begin
                    trn_td     <= {1'b0, hp_tx_pkg::FMT_TYPE_MWR64, {PAD_W{1'b0}},
                                   hp_tx_pkg::CLOSE_LEN_DW, cfg_completer_id, 8'h00, 8'hFF};
                    trn_tsof_n <= 1'b0;
                end
                hp_tx_pkg::BEAT_CLOSE_ADDR: trn_td <= page_base;    // count goes to DW0
                hp_tx_pkg::BEAT_CLOSE_CNT: begin
                    trn_td     <= {cnt_swapped, 32'h0};
                    trn_teof_n <= 1'b0;
                end
                default:                    trn_td <= '0;
            endcase
        end
    end

    a_sof_valid : assert property (@(posedge trn_clk) disable iff (!reset_n)
        !trn_tsof_n |-> !trn_tsrc_rdy_n ##1 (!trn_tsrc_rdy_n && trn_tsof_n))
        else $error("sof without valid beat or not followed by address beat");

endmodule

/* rtl/hp_tx_top.sv */
//////////////////////////////
// huge-page transmit engine, writes buffered packets to host pages as MWr TLPs
//////////////////////////////

module hp_tx_top (
    input  logic                                trn_clk,
    input  logic                                reset_n,
    // producer
    input  logic                                trigger_tlp,
    input  logic                                send_last_tlp_change_huge_page,
    input  logic                                change_huge_page,
    input  logic [hp_tx_pkg::QCNT_W-1:0]        qwords_to_send,
    output logic                                trigger_tlp_ack,
    output logic                                change_huge_page_ack,
    output logic                                tx_ready,
    // host pages
    input  logic [hp_tx_pkg::QWORD_W-1:0]       huge_page_addr_1,
    input  logic [hp_tx_pkg::QWORD_W-1:0]       huge_page_addr_2,
    input  logic                                huge_page_status_1,
    input  logic                                huge_page_status_2,
    output logic                                huge_page_free_1,
    output logic                                huge_page_free_2,
    // read buffer
    output logic [hp_tx_pkg::BUF_AW-1:0]        rd_addr,
    input  logic [hp_tx_pkg::QWORD_W-1:0]       rd_data,
    output logic [hp_tx_pkg::BUF_AW-1:0]        commited_rd_address,
    // transaction interface
    input  logic [hp_tx_pkg::REQ_ID_W-1:0]      cfg_completer_id,
    output logic [hp_tx_pkg::QWORD_W-1:0]       trn_td,
    output logic [hp_tx_pkg::QWORD_W/8-1:0]     trn_trem_n,
    output logic                                trn_tsof_n,
    output logic                                trn_teof_n,
    output logic                                trn_tsrc_rdy_n,
    output logic                                cfg_interrupt_n,
    input  logic                                cfg_interrupt_rdy_n
);

    logic [hp_tx_pkg::QWORD_W-1:0]      page_base;      // current slot address
    logic                               page_available;
    logic                               page_return;
    logic                               load_page;
    logic                               start_tlp;
    logic                               next_beat;
    logic                               end_tlp;
    logic                               last_beat;
    hp_tx_pkg::beat_sel_t               beat_sel;
    logic [hp_tx_pkg::QWORD_W-1:0]      host_addr;
    logic [hp_tx_pkg::TAG_BITS-1:0]     tlp_tag;
    logic [hp_tx_pkg::QCNT_W-1:0]       qwords_in_tlp;
    logic [hp_tx_pkg::PAGE_CNT_W-1:0]   page_qwords;

    hp_page_slots u_slots (.trn_clk, .reset_n, .huge_page_addr_1, .huge_page_addr_2,
        .huge_page_status_1, .huge_page_status_2, .page_return, .page_base,
        .page_available, .huge_page_free_1, .huge_page_free_2);

    hp_tx_fsm u_fsm (.trn_clk, .reset_n, .trigger_tlp, .send_last_tlp_change_huge_page,
        .change_huge_page, .page_available, .last_beat, .cfg_interrupt_rdy_n, .load_page,
        .start_tlp, .next_beat, .end_tlp, .beat_sel, .page_return, .trigger_tlp_ack,
        .change_huge_page_ack, .tx_ready, .cfg_interrupt_n);

    hp_tx_counters u_cnt (.trn_clk, .reset_n, .load_page, .start_tlp, .next_beat, .end_tlp,
        .page_base, .qwords_to_send, .rd_addr, .commited_rd_address, .host_addr, .tlp_tag,
        .qwords_in_tlp, .page_qwords, .last_beat);

    hp_tlp_formatter u_fmt (.trn_clk, .reset_n, .beat_sel, .cfg_completer_id, .qwords_in_tlp,
        .tlp_tag, .host_addr, .page_base, .page_qwords, .rd_data, .trn_td, .trn_trem_n,
        .trn_tsof_n, .trn_teof_n, .trn_tsrc_rdy_n);

endmodule

/* dv/hp_tx_tb.sv */
//////////////////////////////
// testbench for the huge-page transmit engine, table of operations and buffer model
//////////////////////////////

module hp_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OP_TRIG   = 0;
    localparam int OP_LAST   = 1;                       // data TLP then page close
    localparam int OP_CHANGE = 2;
    localparam int OP_BLOCK  = 3;                       // trigger while not ready
    localparam logic [63:0] PAGE_ADDR_1  = 64'h0000_0001_2340_0000;
    localparam logic [63:0] PAGE_ADDR_2  = 64'h0000_0002_5670_0000;
    localparam logic [15:0] COMPLETER_ID = 16'h01A0;

    logic        trn_clk;
    logic        reset_n;
    logic        trigger_tlp;
    logic        send_last_tlp_change_huge_page;
    logic        change_huge_page;
    logic [4:0]  qwords_to_send;
    logic        trigger_tlp_ack;
    logic        change_huge_page_ack;
    logic        tx_ready;
    logic        huge_page_status_1;
    logic        huge_page_status_2;
    logic        huge_page_free_1;
    logic        huge_page_free_2;
    logic [8:0]  rd_addr;
    logic [63:0] rd_data;
    logic [8:0]  commited_rd_address;
    logic [63:0] trn_td;
    logic [7:0]  trn_trem_n;
    logic        trn_tsof_n;
    logic        trn_teof_n;
    logic        trn_tsrc_rdy_n;
    logic        cfg_interrupt_n;
    logic        cfg_interrupt_rdy_n;

    logic [63:0] buf_mem [0:511];                       // packet buffer contents
    logic [8:0]  rd_addr_q;
    integer      seed;
    int          op_tab[$];
    int          n_tab[$];
    int          st_tab[$];                             // slot status raised before row
    int          cycles;
    int          cycle_limit;
    int          checks;
    int          errors;
    int          exp_slot;                              // reference model state
    logic [63:0] exp_base;
    logic [63:0] exp_offset;
    logic [31:0] exp_page_q;
    logic [31:0] exp_tlp_num;
    logic [8:0]  exp_rd_ptr;

    hp_tx_top u_dut (.trn_clk, .reset_n, .trigger_tlp, .send_last_tlp_change_huge_page,
        .change_huge_page, .qwords_to_send, .trigger_tlp_ack, .change_huge_page_ack, .tx_ready,
        .huge_page_addr_1(PAGE_ADDR_1), .huge_page_addr_2(PAGE_ADDR_2), .huge_page_status_1,
        .huge_page_status_2, .huge_page_free_1, .huge_page_free_2, .rd_addr, .rd_data,
        .commited_rd_address, .cfg_completer_id(COMPLETER_ID), .trn_td, .trn_trem_n,
        .trn_tsof_n, .trn_teof_n, .trn_tsrc_rdy_n, .cfg_interrupt_n, .cfg_interrupt_rdy_n);

    always #20 trn_clk = ~trn_clk;                      // 40 ns period

    always @(posedge trn_clk) begin
        #2;
        rd_data   <= buf_mem[rd_addr_q];                // one-cycle read latency
        rd_addr_q <= rd_addr;
    end

    always @(posedge trn_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: engine stalled after %0d cycles, %0d errors", cycles, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [63:0] reverse_bytes64(input logic [63:0] v);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = v[8*(7-i) +: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] reverse_bytes32(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    function automatic logic [63:0] mwr_header(input logic [9:0] len_dw, input logic [7:0] tag);
        logic [63:0] h;
        h        = '0;
        h[62:56] = 7'b1100000;                          // MWr, 4DW header with data
        h[41:32] = len_dw;
        h[31:16] = COMPLETER_ID;
        h[15:8]  = tag;
        h[7:0]   = 8'hFF;                               // first and last byte enables
        return h;
    endfunction

    function automatic int compute_limit();
        int total;
        total = 0;
        for (int i = 0; i < op_tab.size(); i++) begin
            if (op_tab[i] == OP_TRIG || op_tab[i] == OP_LAST) total += n_tab[i] + 4;
            if (op_tab[i] == OP_LAST || op_tab[i] == OP_CHANGE) total += 20;
        end
        return 2 * total + 100;
    endfunction

    task automatic add_row(input int op, input int n, input int st);
        op_tab.push_back(op);
        n_tab.push_back(n);
        st_tab.push_back(st);
    endtask

    task automatic next_cycle();
        @(posedge trn_clk);
        #2;                                             // outputs settled, inputs driven here
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t ns: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_idle_bus(input string what);
        check_value(trn_tsrc_rdy_n, 1'b1, {what, " tsrc_rdy_n"});
        check_value(trn_tsof_n, 1'b1, {what, " tsof_n"});
        check_value(trn_teof_n, 1'b1, {what, " teof_n"});
        check_value(trn_trem_n, 8'hFF, {what, " trem_n"});
        check_value(trn_td, '0, {what, " td"});
    endtask

    task automatic check_beat(input bit sof, input bit eof, input logic [63:0] td,
                              input string what);
        check_value(trn_tsrc_rdy_n, 1'b0, {what, " tsrc_rdy_n"});
        check_value(trn_tsof_n, !sof, {what, " tsof_n"});
        check_value(trn_teof_n, !eof, {what, " teof_n"});
        check_value(trn_trem_n, 8'h00, {what, " trem_n"});
        check_value(trn_td, td, {what, " td"});
    endtask

    task automatic check_side_pulses(input bit ack, input bit cack, input string what);
        check_value(trigger_tlp_ack, ack, {what, " trigger ack"});
        check_value(change_huge_page_ack, cack, {what, " change ack"});
        check_value(huge_page_free_1, 1'b0, {what, " free 1"});
        check_value(huge_page_free_2, 1'b0, {what, " free 2"});
    endtask

    task automatic wait_ready();
        while (tx_ready !== 1'b1) next_cycle();          // bounded by the cycle limit
    endtask

    task automatic strobe_one_cycle(input int op, input int n);
        qwords_to_send                 = n[4:0];
        trigger_tlp                    = (op == OP_TRIG || op == OP_BLOCK);
        send_last_tlp_change_huge_page = (op == OP_LAST);
        change_huge_page               = (op == OP_CHANGE);
        next_cycle();
        trigger_tlp                    = 1'b0;
        send_last_tlp_change_huge_page = 1'b0;
        change_huge_page               = 1'b0;
    endtask

    // called one cycle after the strobe was taken
    task automatic run_data_tlp(input int n, input bit last);
        logic [9:0] len;
        logic [8:0] ptr;
        len = 10'(2 * n);
        ptr = exp_rd_ptr + 9'(n);
        check_beat(1'b1, 1'b0, mwr_header(len, {4'h0, exp_tlp_num[3:0]}), "data header");
        check_side_pulses(1'b0, 1'b0, "data header");
        check_value(commited_rd_address, ptr, "commited_rd_address");
        next_cycle();
        check_beat(1'b0, 1'b0, exp_base + 64'd128 + exp_offset, "data address");
        check_side_pulses(1'b1, 1'b0, "data address");
        for (int i = 0; i < n; i++) begin
            next_cycle();
            ptr = exp_rd_ptr + 9'(i);
            check_beat(1'b0, i == n - 1, reverse_bytes64(buf_mem[ptr]),
                       $sformatf("payload %0d", i));
            check_side_pulses(1'b0, 1'b0, "payload");
        end
        next_cycle();
        check_idle_bus("after data TLP");
        check_value(tx_ready, !last, "tx_ready after data TLP");
        exp_offset  = exp_offset + 64'(8 * n);          // look-ahead bookkeeping
        exp_page_q  = exp_page_q + 32'(n);
        exp_tlp_num = exp_tlp_num + 1;
        exp_rd_ptr  = exp_rd_ptr + 9'(n);
    endtask

    task automatic run_close();
        int wait_cycles;
        check_beat(1'b1, 1'b0, mwr_header(10'd2, 8'h00), "close header");
        check_side_pulses(1'b0, 1'b0, "close header");
        next_cycle();
        check_beat(1'b0, 1'b0, exp_base, "close address");
        check_value(change_huge_page_ack, 1'b1, "change ack on close address");
        check_value(huge_page_free_1, exp_slot == 1, "free 1 on close address");
        check_value(huge_page_free_2, exp_slot == 2, "free 2 on close address");
        if (exp_slot == 1) huge_page_status_1 = 1'b0;   // host takes page back
        else huge_page_status_2 = 1'b0;
        next_cycle();
        check_beat(1'b0, 1'b1, {reverse_bytes32(exp_page_q), 32'h0}, "close count");
        check_side_pulses(1'b0, 1'b0, "close count");
        next_cycle();
        check_idle_bus("after close TLP");
        check_value(cfg_interrupt_n, 1'b0, "interrupt request after close");
        wait_cycles = ({$random(seed)} % 4) + 1;        // host latency
        repeat (wait_cycles) begin
            next_cycle();
            check_value(cfg_interrupt_n, 1'b0, "interrupt request held");
        end
        cfg_interrupt_rdy_n = 1'b0;
        next_cycle();
        cfg_interrupt_rdy_n = 1'b1;
        check_value(cfg_interrupt_n, 1'b1, "interrupt request released");
        exp_slot   = 3 - exp_slot;                      // slots alternate
        exp_base   = (exp_slot == 1) ? PAGE_ADDR_1 : PAGE_ADDR_2;
        exp_offset = '0;
        exp_page_q = '0;
    endtask

    task automatic blocked_trigger(input int n);
        check_value(tx_ready, 1'b0, "tx_ready with no page");
        strobe_one_cycle(OP_BLOCK, n);
        repeat (8) begin
            check_value(trn_tsrc_rdy_n, 1'b1, "no TLP from ignored trigger");
            check_value(tx_ready, 1'b0, "tx_ready stays low");
            next_cycle();
        end
    endtask

    initial begin
        trn_clk                        = 1'b0;
        reset_n                        = 1'b0;
        trigger_tlp                    = 1'b0;
        send_last_tlp_change_huge_page = 1'b0;
        change_huge_page               = 1'b0;
        qwords_to_send                 = '0;
        huge_page_status_1             = 1'b0;
        huge_page_status_2             = 1'b0;
        cfg_interrupt_rdy_n            = 1'b1;
        rd_data                        = '0;
        rd_addr_q                      = '0;
        cycles                         = 0;
        checks                         = 0;
        errors                         = 0;
        seed                           = 93707;
        for (int i = 0; i < 512; i++) begin
            buf_mem[i] = {$random(seed), $random(seed)};
        end
        add_row(OP_TRIG, 4, 1);                         // first page in slot 1
        add_row(OP_TRIG, 1, 0);
        add_row(OP_TRIG, 31, 0);
        add_row(OP_TRIG, 7, 0);
        add_row(OP_CHANGE, 0, 0);
        add_row(OP_BLOCK, 3, 0);                        // slot 2 still empty
        add_row(OP_TRIG, 5, 2);
        add_row(OP_TRIG, 16, 0);
        add_row(OP_LAST, 9, 1);                         // back to slot 1
        add_row(OP_TRIG, 2, 0);
        add_row(OP_CHANGE, 0, 0);
        add_row(OP_TRIG, 3, 2);
        cycle_limit = compute_limit();
        exp_slot    = 1;
        exp_base    = PAGE_ADDR_1;
        exp_offset  = '0;
        exp_page_q  = '0;
        exp_tlp_num = '0;
        exp_rd_ptr  = '0;

        repeat (3) @(posedge trn_clk);
        #2;
        reset_n = 1'b1;
        repeat (4) begin                                // no page handed over yet
            check_idle_bus("after reset");
            check_side_pulses(1'b0, 1'b0, "after reset");
            check_value(tx_ready, 1'b0, "tx_ready after reset");
            check_value(cfg_interrupt_n, 1'b1, "interrupt after reset");
            next_cycle();
        end

        for (int row = 0; row < op_tab.size(); row++) begin
            if (st_tab[row] == 1) huge_page_status_1 = 1'b1;
            if (st_tab[row] == 2) huge_page_status_2 = 1'b1;
            if (op_tab[row] == OP_BLOCK) begin
                blocked_trigger(n_tab[row]);
            end else begin
                wait_ready();
                strobe_one_cycle(op_tab[row], n_tab[row]);
                if (op_tab[row] == OP_CHANGE) begin
                    run_close();
                end else begin
                    run_data_tlp(n_tab[row], op_tab[row] == OP_LAST);
                    if (op_tab[row] == OP_LAST) begin
                        next_cycle();                   // close taken from READY
                        run_close();
                    end
                end
            end
        end

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* hp_tx.f */
rtl/hp_tx_pkg.sv
rtl/hp_page_slots.sv
rtl/hp_tx_fsm.sv
rtl/hp_tx_counters.sv
rtl/hp_tlp_formatter.sv
rtl/hp_tx_top.sv
dv/hp_tx_tb.sv

/* Bender.yml */
package:
  name: hp_tx

sources:
  - rtl/hp_tx_pkg.sv
  - rtl/hp_page_slots.sv
  - rtl/hp_tx_fsm.sv
  - rtl/hp_tx_counters.sv
  - rtl/hp_tlp_formatter.sv
  - rtl/hp_tx_top.sv
  - target: simulation
    files:
      - dv/hp_tx_tb.sv
